// ==== src/csr_defs.svh ====
/* Constants for a machine-mode-only RV32 CSR unit with a single hart.
   XLEN is fixed at 32; the counters are 64 bits, read in two halves */
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// Data path and bus widths
`define XLEN            32
`define CNT_W           64
`define CSR_ADDR_W      12
`define REG_ADDR_W      5
`define IRQ_NB          3
`define SYNC_DEPTH      2

// Instruction word fields
`define FUNCT3_W        3
`define FUNCT3_POS      12
`define RD_POS          7
`define RS1_POS         15
`define ZIMM_W          5
`define ZIMM_POS        15
`define CSR_POS         20

// Zicsr funct3 codes
`define CSRRW           3'b001
`define CSRRS           3'b010
`define CSRRC           3'b011
`define CSRRWI          3'b101
`define CSRRSI          3'b110
`define CSRRCI          3'b111

////////////////////////////////////////////////////////////////////////////
// CSR addresses
////////////////////////////////////////////////////////////////////////////
`define CSR_MSTATUS     12'h300
`define CSR_MISA        12'h301
`define CSR_MIE         12'h304
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MTVAL       12'h343
`define CSR_MIP         12'h344
`define CSR_CYCLE       12'hC00
`define CSR_TIME        12'hC01
`define CSR_INSTRET     12'hC02
`define CSR_CYCLEH      12'hC80
`define CSR_TIMEH       12'hC81
`define CSR_INSTRETH    12'hC82
`define CSR_MHARTID     12'hF14

// MXL=1, I and M present
`define MISA_VALUE      32'h4000_1100
`define HART_ID_VALUE   32'h0000_0000

// Interrupt bits in mip and mie
`define MEIP_BIT        11
`define MTIP_BIT        7
`define MSIP_BIT        3

// mstatus fields kept in machine-only mode
`define MSTATUS_MIE     3
`define MSTATUS_MPIE    7
`define MSTATUS_MPP_HI  12
`define MSTATUS_MPP_LO  11

`endif

// ==== src/csr_pkg.sv ====
/* Packed buses shared by the CSR unit modules. Field order sets the bit layout
   seen by the trap controller and by the shared status bus */
`include "csr_defs.svh"

package csr_pkg;

    // Fields of a Zicsr instruction word
    typedef struct packed {
        logic [`FUNCT3_W-1:0]   funct3;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`ZIMM_W-1:0]     zimm;
        logic [`CSR_ADDR_W-1:0] csr;
    } csr_inst_t;

    // Software write request into the register file
    typedef struct packed {
        logic                   en;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       val;
    } csr_write_t;

    // Trap controller side, each strobe qualifies its value
    typedef struct packed {
        logic [`CNT_W-1:0] instret;
        logic              clr_meip;
        logic              mtval_wr;
        logic [`XLEN-1:0]  mtval;
        logic              mcause_wr;
        logic [`XLEN-1:0]  mcause;
        logic              mstatus_wr;
        logic [`XLEN-1:0]  mstatus;
        logic              mepc_wr;
        logic [`XLEN-1:0]  mepc;
    } trap_ctrl_t;

    // Registers the rest of the core looks at
    typedef struct packed {
        logic [`XLEN-1:0] mtvec;
        logic [`XLEN-1:0] mepc;
        logic [`XLEN-1:0] mstatus;
        logic             glb_mie;
        logic             meip;
        logic             mtip;
        logic             msip;
    } csr_status_t;

    // Integer register file write port
    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] addr;
        logic [`XLEN-1:0]       val;
    } rd_write_t;

    // Raw or synchronized interrupt lines, MEIP in the top bit
    typedef struct packed {
        logic meip;
        logic mtip;
        logic msip;
    } irq_vec_t;

endpackage

// ==== src/irq_sync.sv ====
/* Flop chain for one asynchronous level. DEPTH must be 2 or more;
   a pulse shorter than one aclk period may be missed */
`include "csr_defs.svh"

module irq_sync #(
    parameter int DEPTH = `SYNC_DEPTH
) (
    input  logic aclk,
    input  logic aresetn,
    input  logic bit_in,
    output logic bit_out
);

    // Stage 0 may go metastable, later stages settle it
    logic [DEPTH-1:0] sync_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[DEPTH-2:0], bit_in};
        end
    end

    // Last stage only
    assign bit_out = sync_q[DEPTH-1];

endmodule

// ==== src/csr_decode.sv ====
/* Zicsr field split and new-value builder. The opcode is not checked:
   instbus must already hold a SYSTEM instruction when valid is high */
`include "csr_defs.svh"

module csr_decode import csr_pkg::*; (
    input  logic             valid,
    input  logic [`XLEN-1:0] instbus,
    input  logic [`XLEN-1:0] rs1_val,
    input  logic [`XLEN-1:0] old_val,
    output csr_inst_t        fields,
    output csr_write_t       csr_wr
);

    logic [`XLEN-1:0] zimm_ext;
    logic             wr_en;
    logic [`XLEN-1:0] new_val;

    ////////////////////////////////////////////////////////////////////////
    // Field extraction
    ////////////////////////////////////////////////////////////////////////

    assign fields.funct3 = instbus[`FUNCT3_POS +: `FUNCT3_W];
    assign fields.rs1    = instbus[`RS1_POS +: `REG_ADDR_W];
    assign fields.rd     = instbus[`RD_POS +: `REG_ADDR_W];
    // zimm shares the rs1 slot
    assign fields.zimm   = instbus[`ZIMM_POS +: `ZIMM_W];
    assign fields.csr    = instbus[`CSR_POS +: `CSR_ADDR_W];

    // Immediate forms zero-extend
    assign zimm_ext = {{(`XLEN-`ZIMM_W){1'b0}}, fields.zimm};

    ////////////////////////////////////////////////////////////////////////
    // Write, set or clear
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        wr_en   = 1'b0;
        new_val = old_val;
        case (fields.funct3)
            `CSRRW: begin
                wr_en   = 1'b1;
                new_val = rs1_val;
            end
            // Set and clear with x0 are pure reads
            `CSRRS: begin
                wr_en   = (fields.rs1 != '0);
                new_val = old_val | rs1_val;
            end
            `CSRRC: begin
                wr_en   = (fields.rs1 != '0);
                new_val = old_val & ~rs1_val;
            end
            `CSRRWI: begin
                wr_en   = 1'b1;
                new_val = zimm_ext;
            end
            // Zero immediate, no write either
            `CSRRSI: begin
                wr_en   = (fields.zimm != '0);
                new_val = old_val | zimm_ext;
            end
            `CSRRCI: begin
                wr_en   = (fields.zimm != '0);
                new_val = old_val & ~zimm_ext;
            end
            default: begin
                wr_en = 1'b0;
            end
        endcase
    end

    // Request only with an accepted instruction
    assign csr_wr = '{en: valid & wr_en, addr: fields.csr, val: new_val};

endmodule

// ==== src/csr_regfile.sv ====
/* Machine CSR storage, read mux and 64-bit time counter. Trap controller
   writes win over software; mip is read-only and unknown addresses read 0 */
`include "csr_defs.svh"

module csr_regfile import csr_pkg::*; (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic [`CSR_ADDR_W-1:0] rd_addr,
    output logic [`XLEN-1:0]       old_val,
    input  csr_write_t             csr_wr,
    input  trap_ctrl_t             ctrl,
    input  logic [`XLEN-1:0]       mip,
    output logic [`XLEN-1:0]       mie,
    output csr_status_t            status
);

    logic [`XLEN-1:0]  mstatus;
    logic [`XLEN-1:0]  mtvec;
    logic [`XLEN-1:0]  mscratch;
    logic [`XLEN-1:0]  mepc;
    logic [`XLEN-1:0]  mcause;
    logic [`XLEN-1:0]  mtval;
    logic [`CNT_W-1:0] time_q;

    // Software write strobes, one per writable CSR
    logic wr_mstatus;
    logic wr_mie;
    logic wr_mtvec;
    logic wr_mscratch;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;

    // Keep MIE, MPIE and MPP
    function automatic logic [`XLEN-1:0] legal_mstatus(input logic [`XLEN-1:0] data);
        logic [`XLEN-1:0] res;
        res = '0;
        res[`MSTATUS_MIE]  = data[`MSTATUS_MIE];
        res[`MSTATUS_MPIE] = data[`MSTATUS_MPIE];
        res[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] = data[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO];
        return res;
    endfunction

    // IALIGN=32, low bits never stored
    function automatic logic [`XLEN-1:0] align_mepc(input logic [`XLEN-1:0] data);
        return {data[`XLEN-1:2], 2'b00};
    endfunction

    assign wr_mstatus  = csr_wr.en && (csr_wr.addr == `CSR_MSTATUS);
    assign wr_mie      = csr_wr.en && (csr_wr.addr == `CSR_MIE);
    assign wr_mtvec    = csr_wr.en && (csr_wr.addr == `CSR_MTVEC);
    assign wr_mscratch = csr_wr.en && (csr_wr.addr == `CSR_MSCRATCH);
    assign wr_mepc     = csr_wr.en && (csr_wr.addr == `CSR_MEPC);
    assign wr_mcause   = csr_wr.en && (csr_wr.addr == `CSR_MCAUSE);
    assign wr_mtval    = csr_wr.en && (csr_wr.addr == `CSR_MTVAL);

    ////////////////////////////////////////////////////////////////////////
    // Writable machine CSRs
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else begin
            // Trap side first on the four shared registers
            if (ctrl.mstatus_wr) begin
                mstatus <= legal_mstatus(ctrl.mstatus);
            end else if (wr_mstatus) begin
                mstatus <= legal_mstatus(csr_wr.val);
            end
            if (ctrl.mepc_wr) begin
                mepc <= align_mepc(ctrl.mepc);
            end else if (wr_mepc) begin
                mepc <= align_mepc(csr_wr.val);
            end
            if (ctrl.mcause_wr) begin
                mcause <= ctrl.mcause;
            end else if (wr_mcause) begin
                mcause <= csr_wr.val;
            end
            if (ctrl.mtval_wr) begin
                mtval <= ctrl.mtval;
            end else if (wr_mtval) begin
                mtval <= csr_wr.val;
            end
            // Software only
            if (wr_mie) begin
                mie <= csr_wr.val;
            end
            if (wr_mtvec) begin
                mtvec <= csr_wr.val;
            end
            if (wr_mscratch) begin
                mscratch <= csr_wr.val;
            end
        end
    end

    // Free-running, also serves as cycle
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            time_q <= '0;
        end else begin
            time_q <= time_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // Read mux
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (rd_addr)
            `CSR_MSTATUS:  old_val = mstatus;
            `CSR_MISA:     old_val = `MISA_VALUE;
            `CSR_MIE:      old_val = mie;
            `CSR_MTVEC:    old_val = mtvec;
            `CSR_MSCRATCH: old_val = mscratch;
            `CSR_MEPC:     old_val = mepc;
            `CSR_MCAUSE:   old_val = mcause;
            `CSR_MTVAL:    old_val = mtval;
            `CSR_MIP:      old_val = mip;
            `CSR_CYCLE,
            `CSR_TIME:     old_val = time_q[`XLEN-1:0];
            `CSR_CYCLEH,
            `CSR_TIMEH:    old_val = time_q[`CNT_W-1:`XLEN];
            `CSR_INSTRET:  old_val = ctrl.instret[`XLEN-1:0];
            `CSR_INSTRETH: old_val = ctrl.instret[`CNT_W-1:`XLEN];
            `CSR_MHARTID:  old_val = `HART_ID_VALUE;
            default:       old_val = '0;
        endcase
    end

    // Shared status bus
    assign status = '{
        mtvec:   mtvec,
        mepc:    mepc,
        mstatus: mstatus,
        glb_mie: mstatus[`MSTATUS_MIE],
        meip:    mip[`MEIP_BIT],
        mtip:    mip[`MTIP_BIT],
        msip:    mip[`MSIP_BIT]
    };

endmodule

// ==== src/irq_pending.sv ====
/* mip pending bits from already synchronized lines. MEIP stays set until
   the trap controller clears it; a same-cycle set wins over the clear */
`include "csr_defs.svh"

module irq_pending import csr_pkg::*; (
    input  logic             aclk,
    input  logic             aresetn,
    input  irq_vec_t         irq_sync,
    input  logic [`XLEN-1:0] mie,
    input  logic             clr_meip,
    output logic [`XLEN-1:0] mip
);

    logic meip_q;
    logic mtip_q;
    logic msip_q;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            meip_q <= 1'b0;
            mtip_q <= 1'b0;
            msip_q <= 1'b0;
        end else begin
            // Level-following, gated by enable
            mtip_q <= irq_sync.mtip & mie[`MTIP_BIT];
            msip_q <= irq_sync.msip & mie[`MSIP_BIT];
            // Sticky external pending
            if (irq_sync.meip && mie[`MEIP_BIT]) begin
                meip_q <= 1'b1;
            end else if (clr_meip) begin
                meip_q <= 1'b0;
            end
        end
    end

    // Only three live bits
    always_comb begin
        mip            = '0;
        mip[`MEIP_BIT] = meip_q;
        mip[`MTIP_BIT] = mtip_q;
        mip[`MSIP_BIT] = msip_q;
    end

endmodule

// ==== src/csr_unit.sv ====
/* Machine-mode CSR unit top. No back-pressure: every valid cycle is an
   accepted instruction, and rd is written one cycle later */
`include "csr_defs.svh"

module csr_unit import csr_pkg::*; (
    input  logic                   aclk,
    input  logic                   aresetn,
    input  logic                   valid,
    input  logic [`XLEN-1:0]       instbus,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    input  logic [`XLEN-1:0]       rs1_val,
    output rd_write_t              rd_write,
    input  trap_ctrl_t             ctrl,
    output csr_status_t            status,
    input  irq_vec_t               irq
);

    csr_inst_t              fields;
    csr_write_t             csr_wr;
    logic [`XLEN-1:0]       old_val;
    logic [`XLEN-1:0]       mie;
    logic [`XLEN-1:0]       mip;
    logic [`IRQ_NB-1:0]     irq_raw;
    logic [`IRQ_NB-1:0]     irq_synced;
    irq_vec_t               irq_sync_vec;
    logic                   rd_en_q;
    logic [`REG_ADDR_W-1:0] rd_addr_q;
    logic [`XLEN-1:0]       rd_val_q;

    // rs1 lookup is combinational
    assign rs1_addr = fields.rs1;

    csr_decode u_decode (
        .valid   (valid),
        .instbus (instbus),
        .rs1_val (rs1_val),
        .old_val (old_val),
        .fields  (fields),
        .csr_wr  (csr_wr)
    );

    csr_regfile u_regfile (
        .aclk    (aclk),
        .aresetn (aresetn),
        .rd_addr (fields.csr),
        .old_val (old_val),
        .csr_wr  (csr_wr),
        .ctrl    (ctrl),
        .mip     (mip),
        .mie     (mie),
        .status  (status)
    );

    ////////////////////////////////////////////////////////////////////////
    // Interrupt path
    ////////////////////////////////////////////////////////////////////////

    assign irq_raw = irq;

    for (genvar i = 0; i < `IRQ_NB; i++) begin : g_irq_sync
        irq_sync #(
            .DEPTH (`SYNC_DEPTH)
        ) u_irq_sync (
            .aclk    (aclk),
            .aresetn (aresetn),
            .bit_in  (irq_raw[i]),
            .bit_out (irq_synced[i])
        );
    end

    assign irq_sync_vec = irq_synced;

    irq_pending u_pending (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .irq_sync (irq_sync_vec),
        .mie      (mie),
        .clr_meip (ctrl.clr_meip),
        .mip      (mip)
    );

    ////////////////////////////////////////////////////////////////////////
    // rd write stage
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            rd_en_q <= 1'b0;
        end else begin
            rd_en_q <= valid;
        end
    end

    // Value sampled before this edge's CSR write lands
    always_ff @(posedge aclk) begin
        rd_addr_q <= fields.rd;
        rd_val_q  <= old_val;
    end

    assign rd_write = '{en: rd_en_q, addr: rd_addr_q, val: rd_val_q};

endmodule

// ==== test/csr_unit_assert.sv ====
/* Bound into csr_unit; checks rd timing, mepc alignment and the live mip bits.
   Properties are off while aresetn is low */
`include "csr_defs.svh"

module csr_unit_assert (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             valid,
    input  logic             rd_en,
    input  logic [1:0]       mepc_lo,
    input  logic [`XLEN-1:0] mip
);

    // Only MEIP, MTIP and MSIP may ever be set
    localparam logic [`XLEN-1:0] MIP_LIVE =
        (32'h1 << `MEIP_BIT) | (32'h1 << `MTIP_BIT) | (32'h1 << `MSIP_BIT);

    // Number of failed properties so far
    int fail_cnt = 0;

    // One-cycle rd write latency
    a_rd_en_delay: assert property (@(posedge aclk) disable iff (!aresetn)
        rd_en == $past(valid))
        else begin
            fail_cnt++;
            $error("rd_write.en does not follow valid by one cycle");
        end

    a_mepc_aligned: assert property (@(posedge aclk) disable iff (!aresetn)
        mepc_lo == 2'b00)
        else begin
            fail_cnt++;
            $error("mepc low bits are not zero on the status bus");
        end

    a_mip_bits: assert property (@(posedge aclk) disable iff (!aresetn)
        (mip & ~MIP_LIVE) == '0)
        else begin
            fail_cnt++;
            $error("mip has a bit set outside MEIP, MTIP and MSIP");
        end

endmodule

bind csr_unit csr_unit_assert u_assert (
    .aclk    (aclk),
    .aresetn (aresetn),
    .valid   (valid),
    .rd_en   (rd_write.en),
    .mepc_lo (status.mepc[1:0]),
    .mip     (mip)
);

// ==== test/csr_unit_tb.sv ====
/* Random Zicsr traffic, trap writes and interrupt toggles against a cycle model.
   Inputs change on the rising edge; outputs are checked on the falling edge */
`include "csr_defs.svh"

module csr_unit_tb import csr_pkg::*; ();

    localparam int NUM_CYCLES    = 3000;
    localparam int DRAIN_TIMEOUT = 20;
    // MIE, MPIE and MPP
    localparam logic [`XLEN-1:0] MSTATUS_MASK = 32'h0000_1888;

    logic                   aclk = 1'b0;
    logic                   aresetn;
    logic                   valid;
    logic [`XLEN-1:0]       instbus;
    logic [`REG_ADDR_W-1:0] rs1_addr;
    logic [`XLEN-1:0]       rs1_val;
    rd_write_t              rd_write;
    trap_ctrl_t             ctrl;
    csr_status_t            status;
    irq_vec_t               irq;

    // Integer register file seen by the DUT
    logic [`XLEN-1:0] xreg [0:31];

    // Reference model state
    logic [`XLEN-1:0]       exp_mstatus, exp_mie, exp_mtvec, exp_mscratch;
    logic [`XLEN-1:0]       exp_mepc, exp_mcause, exp_mtval;
    logic [`CNT_W-1:0]      exp_time;
    logic                   exp_meip, exp_mtip, exp_msip;
    irq_vec_t               sync1, sync2;
    logic                   exp_rd_en;
    logic [`REG_ADDR_W-1:0] exp_rd_addr;
    logic [`XLEN-1:0]       exp_rd_val;
    int                     wait_cnt;
    logic                   drained;

    always #5 aclk = ~aclk;

    assign rs1_val = xreg[rs1_addr];

    csr_unit u_csr_unit (
        .aclk     (aclk),
        .aresetn  (aresetn),
        .valid    (valid),
        .instbus  (instbus),
        .rs1_addr (rs1_addr),
        .rs1_val  (rs1_val),
        .rd_write (rd_write),
        .ctrl     (ctrl),
        .status   (status),
        .irq      (irq)
    );

    // Bound checker failures stop the run too
    always @(u_csr_unit.u_assert.fail_cnt) begin
        if (u_csr_unit.u_assert.fail_cnt != 0) begin
            $display("test failed");
            $display("A concurrent assertion in the bound checker failed");
            $fatal(1, "Assertion failure");
        end
    end

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("test failed");
            $display("FAILED at time %0t: %s got 0x%0h expected 0x%0h",
                     $time, what, got, exp);
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    function automatic logic [`XLEN-1:0] model_mip();
        return ({31'b0, exp_meip} << `MEIP_BIT) | ({31'b0, exp_mtip} << `MTIP_BIT) |
               ({31'b0, exp_msip} << `MSIP_BIT);
    endfunction

    // Architectural read value of one CSR
    function automatic logic [`XLEN-1:0] model_read(input logic [11:0] addr);
        case (addr)
            `CSR_MSTATUS:              return exp_mstatus;
            `CSR_MISA:                 return `MISA_VALUE;
            `CSR_MIE:                  return exp_mie;
            `CSR_MTVEC:                return exp_mtvec;
            `CSR_MSCRATCH:             return exp_mscratch;
            `CSR_MEPC:                 return exp_mepc;
            `CSR_MCAUSE:               return exp_mcause;
            `CSR_MTVAL:                return exp_mtval;
            `CSR_MIP:                  return model_mip();
            `CSR_CYCLE, `CSR_TIME:     return exp_time[31:0];
            `CSR_CYCLEH, `CSR_TIMEH:   return exp_time[63:32];
            `CSR_INSTRET:              return ctrl.instret[31:0];
            `CSR_INSTRETH:             return ctrl.instret[63:32];
            `CSR_MHARTID:              return `HART_ID_VALUE;
            default:                   return '0;
        endcase
    endfunction

    // Implemented addresses plus a few holes
    function automatic logic [11:0] pick_csr_addr(input int unsigned sel);
        case (sel)
            0:  return `CSR_MSTATUS;
            1:  return `CSR_MISA;
            2:  return `CSR_MIE;
            3:  return `CSR_MTVEC;
            4:  return `CSR_MSCRATCH;
            5:  return `CSR_MEPC;
            6:  return `CSR_MCAUSE;
            7:  return `CSR_MTVAL;
            8:  return `CSR_MIP;
            9:  return `CSR_CYCLE;
            10: return `CSR_TIME;
            11: return `CSR_INSTRET;
            12: return `CSR_CYCLEH;
            13: return `CSR_TIMEH;
            14: return `CSR_INSTRETH;
            15: return `CSR_MHARTID;
            16: return 12'h302;
            default: return 12'h7C0;
        endcase
    endfunction

    task automatic check_outputs();
        // rs1 index sits in bits 19:15 of the instruction word
        check_value("rs1_addr", rs1_addr, instbus[19:15]);
        check_value("rd_write.en", rd_write.en, exp_rd_en);
        if (exp_rd_en) begin
            check_value("rd_write.addr", rd_write.addr, exp_rd_addr);
            check_value("rd_write.val", rd_write.val, exp_rd_val);
        end
        check_value("status.mtvec", status.mtvec, exp_mtvec);
        check_value("status.mepc", status.mepc, exp_mepc);
        check_value("status.mstatus", status.mstatus, exp_mstatus);
        check_value("status.glb_mie", status.glb_mie, exp_mstatus[`MSTATUS_MIE]);
        check_value("status.meip", status.meip, exp_meip);
        check_value("status.mtip", status.mtip, exp_mtip);
        check_value("status.msip", status.msip, exp_msip);
    endtask

    // Advance the model by one rising edge using the current inputs
    task automatic step_model();
        logic [2:0]       f3;
        logic [4:0]       rs1;
        logic [11:0]      addr;
        logic [`XLEN-1:0] old;
        logic [`XLEN-1:0] opnd;
        logic [`XLEN-1:0] nval;
        logic             wen;
        f3   = instbus[14:12];
        rs1  = instbus[19:15];
        addr = instbus[31:20];
        old  = model_read(addr);
        // funct3[2] selects the zero-extended immediate
        opnd = f3[2] ? {27'b0, rs1} : xreg[rs1];
        case (f3[1:0])
            2'b01:   nval = opnd;
            2'b10:   nval = old | opnd;
            2'b11:   nval = old & ~opnd;
            default: nval = old;
        endcase
        wen = valid && ((f3[1:0] == 2'b01) || ((f3[1:0] != 2'b00) && (rs1 != 5'd0)));
        exp_rd_en   = valid;
        exp_rd_addr = instbus[11:7];
        exp_rd_val  = old;
        // Pending bits see the enables from before this edge
        exp_mtip = sync2.mtip & exp_mie[`MTIP_BIT];
        exp_msip = sync2.msip & exp_mie[`MSIP_BIT];
        if (sync2.meip && exp_mie[`MEIP_BIT]) exp_meip = 1'b1;
        else if (ctrl.clr_meip) exp_meip = 1'b0;
        sync2 = sync1;
        sync1 = irq;
        // Trap controller beats software
        if (ctrl.mstatus_wr) exp_mstatus = ctrl.mstatus & MSTATUS_MASK;
        else if (wen && addr == `CSR_MSTATUS) exp_mstatus = nval & MSTATUS_MASK;
        if (ctrl.mepc_wr) exp_mepc = ctrl.mepc & ~32'h3;
        else if (wen && addr == `CSR_MEPC) exp_mepc = nval & ~32'h3;
        if (ctrl.mcause_wr) exp_mcause = ctrl.mcause;
        else if (wen && addr == `CSR_MCAUSE) exp_mcause = nval;
        if (ctrl.mtval_wr) exp_mtval = ctrl.mtval;
        else if (wen && addr == `CSR_MTVAL) exp_mtval = nval;
        if (wen && addr == `CSR_MIE) exp_mie = nval;
        if (wen && addr == `CSR_MTVEC) exp_mtvec = nval;
        if (wen && addr == `CSR_MSCRATCH) exp_mscratch = nval;
        exp_time = exp_time + 64'd1;
    endtask

    task automatic drive_random(input logic allow_valid);
        logic [2:0] f3;
        logic [4:0] rs1;
        int unsigned k;
        case ($urandom_range(5))
            0:       f3 = `CSRRW;
            1:       f3 = `CSRRS;
            2:       f3 = `CSRRC;
            3:       f3 = `CSRRWI;
            4:       f3 = `CSRRSI;
            default: f3 = `CSRRCI;
        endcase
        // Zero operand often enough to hit the read-only forms
        rs1 = ($urandom_range(3) == 0) ? 5'd0 : 5'($urandom_range(31, 1));
        valid   <= allow_valid && ($urandom_range(3) != 0);
        instbus <= {pick_csr_addr($urandom_range(17)), rs1, f3,
                    5'($urandom_range(31)), 7'h73};
        ctrl.mepc_wr    <= ($urandom_range(7) == 0);
        ctrl.mepc       <= $urandom();
        ctrl.mstatus_wr <= ($urandom_range(7) == 0);
        ctrl.mstatus    <= $urandom();
        ctrl.mcause_wr  <= ($urandom_range(7) == 0);
        ctrl.mcause     <= $urandom();
        ctrl.mtval_wr   <= ($urandom_range(7) == 0);
        ctrl.mtval      <= $urandom();
        ctrl.clr_meip   <= ($urandom_range(7) == 0);
        if ($urandom_range(3) == 0) ctrl.instret <= {$urandom(), $urandom()};
        // Lines hold for several cycles between toggles
        if ($urandom_range(5) == 0) irq.meip <= ~irq.meip;
        if ($urandom_range(5) == 0) irq.mtip <= ~irq.mtip;
        if ($urandom_range(5) == 0) irq.msip <= ~irq.msip;
        k = $urandom_range(31, 1);
        xreg[k] <= $urandom();
    endtask

    initial begin
        aresetn  = 1'b0;
        valid    = 1'b0;
        instbus  = '0;
        ctrl     = '0;
        irq      = '0;
        void'($urandom(75));
        for (int i = 0; i < 32; i++) xreg[i] = (i == 0) ? '0 : $urandom();
        {exp_mstatus, exp_mie, exp_mtvec, exp_mscratch} = '0;
        {exp_mepc, exp_mcause, exp_mtval, exp_time} = '0;
        {exp_meip, exp_mtip, exp_msip, exp_rd_en} = '0;
        sync1 = '0;
        sync2 = '0;
        repeat (2) @(posedge aclk);
        aresetn <= 1'b1;

        //////////////////////////////////////////////////////////////////////////
        // Random traffic
        //////////////////////////////////////////////////////////////////////////
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            @(negedge aclk);
            check_outputs();
            step_model();
            @(posedge aclk);
            drive_random(1'b1);
        end

        // Stop issuing and wait for the rd port to go idle
        drained = 1'b0;
        for (wait_cnt = 0; wait_cnt < DRAIN_TIMEOUT && !drained; wait_cnt++) begin
            @(negedge aclk);
            check_outputs();
            drained = (rd_write.en == 1'b0);
            step_model();
            @(posedge aclk);
            drive_random(1'b0);
        end
        if (!drained) begin
            $display("test failed");
            $display("Timeout waiting for rd_write.en to drop after valid went low");
            $fatal(1, "Drain timeout");
        end

        // State after the last edge
        @(negedge aclk);
        check_outputs();

        if (u_csr_unit.u_assert.fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+src
src/csr_pkg.sv
src/irq_sync.sv
src/csr_decode.sv
src/csr_regfile.sv
src/irq_pending.sv
src/csr_unit.sv
test/csr_unit_assert.sv
test/csr_unit_tb.sv

// ==== Bender.yml ====
package:
  name: csr_unit

export_include_dirs:
  - src

sources:
  - files:
      - src/csr_pkg.sv
      - src/irq_sync.sv
      - src/csr_decode.sv
      - src/csr_regfile.sv
      - src/irq_pending.sv
      - src/csr_unit.sv
  - target: test
    files:
      - test/csr_unit_assert.sv
      - test/csr_unit_tb.sv
